// ==== cfg_deposit_settings.svh ====
`ifndef CFG_DEPOSIT_SETTINGS_SVH
`define CFG_DEPOSIT_SETTINGS_SVH

// Width of the register write address
`define CFG_ADDR_W 2

// Width of the write data and of the word on the config link
`define CFG_DATA_W 32

// Register map of the two configuration channels
// Addresses 2 and 3 are not mapped and writes there are dropped
`define CFG_ADDR_TIMER 2'd0
`define CFG_ADDR_MODE  2'd1

`endif

// ==== cfg_deposit_pkg.sv ====
`default_nettype none

package cfg_deposit_pkg;

  // Timer channel payload, 32 bits with the enable in the MSB
  typedef struct packed {
    logic        enable;
    logic [14:0] reserved;
    logic [15:0] period;
  } timer_cfg_t;

  // Mode channel payload, 32 bits with the mode nibble in the LSBs
  typedef struct packed {
    logic [19:0] reserved;
    logic [7:0]  gain;
    logic [3:0]  mode;
  } mode_cfg_t;

  // Tag that travels with every word on the config link
  typedef enum logic {
    CHAN_TIMER = 1'b0,
    CHAN_MODE  = 1'b1
  } cfg_chan_e;

endpackage

`default_nettype wire

// ==== cfg_regs.sv ====
`default_nettype none

`include "cfg_deposit_settings.svh"

module cfg_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Plain write strobe port, there is no handshake on this side
  input  logic                       wr_en_i,
  input  logic [`CFG_ADDR_W-1:0]     wr_addr_i,
  input  logic [`CFG_DATA_W/8-1:0]   wr_be_i,
  input  logic [`CFG_DATA_W-1:0]     wr_data_i,
  // Timer channel update towards its deposit
  output logic                       timer_upd_o,
  output cfg_deposit_pkg::timer_cfg_t timer_o,
  // Mode channel update towards its deposit
  output logic                       mode_upd_o,
  output cfg_deposit_pkg::mode_cfg_t  mode_o
);

  // ----------------------------------------------------------------------
  // Address decode and byte-enable merge
  // ----------------------------------------------------------------------

  logic                        wr_timer;
  logic                        wr_mode;
  logic [`CFG_DATA_W-1:0]      be_mask;
  cfg_deposit_pkg::timer_cfg_t timer_q;
  cfg_deposit_pkg::timer_cfg_t timer_d;
  cfg_deposit_pkg::mode_cfg_t  mode_q;
  cfg_deposit_pkg::mode_cfg_t  mode_d;
  logic                        timer_upd_q;
  logic                        mode_upd_q;

  // Only the two mapped addresses select a register
  assign wr_timer = wr_en_i && (wr_addr_i == `CFG_ADDR_TIMER);
  assign wr_mode  = wr_en_i && (wr_addr_i == `CFG_ADDR_MODE);

  // Expand every byte enable into a full byte of mask bits
  always_comb begin
    for (int i = 0; i < `CFG_DATA_W / 8; i++) begin
      be_mask[8*i +: 8] = {8{wr_be_i[i]}};
    end
  end

  // Enabled bytes come from the write data, the others keep the stored value
  // Reserved fields are merged like any other bits
  assign timer_d = cfg_deposit_pkg::timer_cfg_t'((wr_data_i & be_mask) |
                                                 (timer_q & ~be_mask));
  assign mode_d  = cfg_deposit_pkg::mode_cfg_t'((wr_data_i & be_mask) |
                                                (mode_q & ~be_mask));

  // ----------------------------------------------------------------------
  // Register storage and update pulses
  // ----------------------------------------------------------------------

  // The merged value and the pulse are taken on the same edge, so the
  // deposit sees the new struct in exactly the cycle of the pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timer_q     <= '0;
      mode_q      <= '0;
      timer_upd_q <= 1'b0;
      mode_upd_q  <= 1'b0;
    end else begin
      // A pulse lasts one cycle unless another write follows right away
      timer_upd_q <= wr_timer;
      mode_upd_q  <= wr_mode;
      if (wr_timer) begin
        timer_q <= timer_d;
      end
      if (wr_mode) begin
        mode_q <= mode_d;
      end
    end
  end

  // The stored registers drive the outputs directly
  assign timer_o     = timer_q;
  assign mode_o      = mode_q;
  assign timer_upd_o = timer_upd_q;
  assign mode_upd_o  = mode_upd_q;

endmodule

`default_nettype wire

// ==== stream_deposit.sv ====
`default_nettype none

// Latest-value-wins holding stage between a source without back-pressure
// and a valid/ready sink
module stream_deposit #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Input side is always ready, so it has no ready output
  input  logic valid_i,
  input  T     data_i,
  // Output side with a normal valid/ready handshake
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic pending_d;
  logic pending_q;
  T     data_q;

  // A new input or an old stalled value stays pending until the sink takes it
  // With nothing offered the flag simply holds its state
  assign pending_d = (valid_i || pending_q) ? !ready_i : pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // Newer input overwrites the held value even during a stall
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_q <= data_i;
    end
  end

  // During an input pulse the register is bypassed
  // so the value reaches the sink in the same cycle
  assign valid_o = valid_i || pending_q;
  assign data_o  = valid_i ? data_i : data_q;

endmodule

`default_nettype wire

// ==== cfg_link_tx.sv ====
`default_nettype none

`include "cfg_deposit_settings.svh"

module cfg_link_tx (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Timer deposit output
  input  logic                        timer_valid_i,
  input  cfg_deposit_pkg::timer_cfg_t timer_i,
  output logic                        timer_ready_o,
  // Mode deposit output
  input  logic                        mode_valid_i,
  input  cfg_deposit_pkg::mode_cfg_t  mode_i,
  output logic                        mode_ready_o,
  // Tagged configuration link
  output logic                        cfg_valid_o,
  output cfg_deposit_pkg::cfg_chan_e  cfg_chan_o,
  output logic [`CFG_DATA_W-1:0]      cfg_data_o,
  input  logic                        cfg_ready_i
);

  // ----------------------------------------------------------------------
  // Round-robin grant
  // ----------------------------------------------------------------------

  cfg_deposit_pkg::cfg_chan_e last_q;
  logic                       gnt_timer;
  logic                       gnt_mode;
  logic                       xfer;

  // A lone valid channel is always granted
  // On a tie the channel that was not served last goes first
  assign gnt_timer = timer_valid_i &&
                     (!mode_valid_i || (last_q == cfg_deposit_pkg::CHAN_MODE));
  assign gnt_mode  = mode_valid_i &&
                     (!timer_valid_i || (last_q == cfg_deposit_pkg::CHAN_TIMER));

  // ----------------------------------------------------------------------
  // Link word
  // ----------------------------------------------------------------------

  assign cfg_valid_o = timer_valid_i || mode_valid_i;
  assign cfg_chan_o  = gnt_mode ? cfg_deposit_pkg::CHAN_MODE : cfg_deposit_pkg::CHAN_TIMER;
  assign cfg_data_o  = gnt_mode ? `CFG_DATA_W'(mode_i) : `CFG_DATA_W'(timer_i);

  // Ready is only passed to the deposit that owns the current word
  assign timer_ready_o = cfg_ready_i && gnt_timer;
  assign mode_ready_o  = cfg_ready_i && gnt_mode;

  assign xfer = cfg_valid_o && cfg_ready_i;

  // The last-served flag moves only on a completed transfer
  // Reset points it at the mode channel, which hands the first tie to the timer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= cfg_deposit_pkg::CHAN_MODE;
    end else if (xfer) begin
      last_q <= cfg_chan_o;
    end
  end

endmodule

`default_nettype wire

// ==== cfg_deposit_top.sv ====
`default_nettype none

`include "cfg_deposit_settings.svh"

module cfg_deposit_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Register write port
  input  logic                       wr_en_i,
  input  logic [`CFG_ADDR_W-1:0]     wr_addr_i,
  input  logic [`CFG_DATA_W/8-1:0]   wr_be_i,
  input  logic [`CFG_DATA_W-1:0]     wr_data_i,
  // Configuration link towards the peripheral
  output logic                       cfg_valid_o,
  output cfg_deposit_pkg::cfg_chan_e cfg_chan_o,
  output logic [`CFG_DATA_W-1:0]     cfg_data_o,
  input  logic                       cfg_ready_i
);

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------

  // Register block to deposits
  logic                        timer_upd;
  cfg_deposit_pkg::timer_cfg_t timer_cfg;
  logic                        mode_upd;
  cfg_deposit_pkg::mode_cfg_t  mode_cfg;

  // Deposits to link transmitter
  logic                        timer_dep_valid;
  logic                        timer_dep_ready;
  cfg_deposit_pkg::timer_cfg_t timer_dep_data;
  logic                        mode_dep_valid;
  logic                        mode_dep_ready;
  cfg_deposit_pkg::mode_cfg_t  mode_dep_data;

  cfg_regs i_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_be_i     (wr_be_i),
    .wr_data_i   (wr_data_i),
    .timer_upd_o (timer_upd),
    .timer_o     (timer_cfg),
    .mode_upd_o  (mode_upd),
    .mode_o      (mode_cfg)
  );

  // One deposit per channel, each with its own payload type
  stream_deposit #(
    .T (cfg_deposit_pkg::timer_cfg_t)
  ) i_timer_dep (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (timer_upd),
    .data_i  (timer_cfg),
    .valid_o (timer_dep_valid),
    .ready_i (timer_dep_ready),
    .data_o  (timer_dep_data)
  );

  stream_deposit #(
    .T (cfg_deposit_pkg::mode_cfg_t)
  ) i_mode_dep (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (mode_upd),
    .data_i  (mode_cfg),
    .valid_o (mode_dep_valid),
    .ready_i (mode_dep_ready),
    .data_o  (mode_dep_data)
  );

  cfg_link_tx i_link (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .timer_valid_i (timer_dep_valid),
    .timer_i       (timer_dep_data),
    .timer_ready_o (timer_dep_ready),
    .mode_valid_i  (mode_dep_valid),
    .mode_i        (mode_dep_data),
    .mode_ready_o  (mode_dep_ready),
    .cfg_valid_o   (cfg_valid_o),
    .cfg_chan_o    (cfg_chan_o),
    .cfg_data_o    (cfg_data_o),
    .cfg_ready_i   (cfg_ready_i)
  );

endmodule

`default_nettype wire

// ==== cfg_deposit_sva.sv ====
`default_nettype none

`include "cfg_deposit_settings.svh"

module cfg_link_tx_sva (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        timer_valid_i,
  input cfg_deposit_pkg::timer_cfg_t timer_i,
  input logic                        timer_ready_o,
  input logic                        mode_valid_i,
  input cfg_deposit_pkg::mode_cfg_t  mode_i,
  input logic                        mode_ready_o,
  input logic                        cfg_valid_o,
  input cfg_deposit_pkg::cfg_chan_e  cfg_chan_o,
  input logic [`CFG_DATA_W-1:0]      cfg_data_o,
  input logic                        cfg_ready_i
);

  // A word tagged with a channel carries that channel's valid payload
  timer_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_o && cfg_chan_o == cfg_deposit_pkg::CHAN_TIMER |->
    timer_valid_i && cfg_data_o == `CFG_DATA_W'(timer_i))
    else $error("timer word on the link does not match the timer deposit");

  mode_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_o && cfg_chan_o == cfg_deposit_pkg::CHAN_MODE |->
    mode_valid_i && cfg_data_o == `CFG_DATA_W'(mode_i))
    else $error("mode word on the link does not match the mode deposit");

  // Ready only returns to the channel that owns the current word
  timer_ready_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    timer_ready_o |-> cfg_ready_i && cfg_chan_o == cfg_deposit_pkg::CHAN_TIMER)
    else $error("timer deposit got ready while not granted");

  mode_ready_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode_ready_o |-> cfg_ready_i && cfg_chan_o == cfg_deposit_pkg::CHAN_MODE)
    else $error("mode deposit got ready while not granted");

endmodule

bind cfg_link_tx cfg_link_tx_sva i_link_sva (.*);

`default_nettype wire

// ==== tb_cfg_deposit.sv ====
`default_nettype none

`include "cfg_deposit_settings.svh"

module tb_cfg_deposit;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       wr_en_i;
  logic [`CFG_ADDR_W-1:0]     wr_addr_i;
  logic [`CFG_DATA_W/8-1:0]   wr_be_i;
  logic [`CFG_DATA_W-1:0]     wr_data_i;
  logic                       cfg_valid_o;
  cfg_deposit_pkg::cfg_chan_e cfg_chan_o;
  logic [`CFG_DATA_W-1:0]     cfg_data_o;
  logic                       cfg_ready_i;

  integer seed;
  int     error_count;

  // ----------------------------------------------------------------------
  // Reference model, its state describes the cycle after each edge
  // ----------------------------------------------------------------------

  logic [`CFG_DATA_W-1:0] m_timer;
  logic [`CFG_DATA_W-1:0] m_mode;
  logic                   m_pt;
  logic                   m_pm;
  // Last served channel, 1 means mode
  logic                   m_last;
  logic                   m_xfer;
  logic                   m_gnt;
  // Ready cycles that a pending channel has waited without being served
  int                     age_t;
  int                     age_m;
  logic                   exp_chan;
  logic [`CFG_DATA_W-1:0] exp_data;
  string                  test_name;

  cfg_deposit_top i_cfg_deposit_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_be_i     (wr_be_i),
    .wr_data_i   (wr_data_i),
    .cfg_valid_o (cfg_valid_o),
    .cfg_chan_o  (cfg_chan_o),
    .cfg_data_o  (cfg_data_o),
    .cfg_ready_i (cfg_ready_i)
  );

  always #4 clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    error_count++;
    $display("ERROR %s expected 0x%08h actual 0x%08h", name, exp, act);
    $display("TB FAILED");
    $fatal(1, "mismatch in %s", name);
  endtask

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  // Each set byte enable takes that byte from the write data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  // Lone channel wins, a tie goes to the channel not served last
  function automatic logic pick_channel(input logic tv, input logic mv, input logic last);
    return mv && (!tv || !last);
  endfunction

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      m_timer = '0;
      m_mode  = '0;
      m_pt    = 1'b0;
      m_pm    = 1'b0;
      m_last  = 1'b1;
    end else begin
      m_xfer = (m_pt || m_pm) && cfg_ready_i;
      m_gnt  = pick_channel(m_pt, m_pm, m_last);
      if (m_xfer) begin
        m_last = m_gnt;
        if (m_gnt) m_pm = 1'b0;
        else m_pt = 1'b0;
      end
      // A write shows up as a pending channel one cycle later
      if (wr_en_i && wr_addr_i == `CFG_ADDR_TIMER) begin
        m_timer = merge_bytes(m_timer, wr_data_i, wr_be_i);
        m_pt    = 1'b1;
      end
      if (wr_en_i && wr_addr_i == `CFG_ADDR_MODE) begin
        m_mode = merge_bytes(m_mode, wr_data_i, wr_be_i);
        m_pm   = 1'b1;
      end
    end
  end

  // Outputs are compared mid-cycle where they are settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      age_t = 0;
      age_m = 0;
      assert (cfg_valid_o == 1'b0) else report_mismatch("reset", 0, cfg_valid_o);
    end else begin
      assert (cfg_valid_o == (m_pt || m_pm))
        else report_mismatch("backpressure", m_pt || m_pm, cfg_valid_o);
      if (m_pt || m_pm) begin
        exp_chan  = pick_channel(m_pt, m_pm, m_last);
        exp_data  = exp_chan ? m_mode : m_timer;
        test_name = (m_pt && m_pm) ? "round_robin" : "grant";
        assert (cfg_chan_o == exp_chan) else report_mismatch(test_name, exp_chan, cfg_chan_o);
        assert (cfg_data_o == exp_data) else report_mismatch("latest_value", exp_data, cfg_data_o);
      end
      // A pending channel ages on every ready cycle where the link offers another word
      if (!m_pt || (cfg_ready_i && cfg_valid_o &&
                    cfg_chan_o == cfg_deposit_pkg::CHAN_TIMER)) begin
        age_t = 0;
      end else if (cfg_ready_i) begin
        age_t++;
      end
      if (!m_pm || (cfg_ready_i && cfg_valid_o &&
                    cfg_chan_o == cfg_deposit_pkg::CHAN_MODE)) begin
        age_m = 0;
      end else if (cfg_ready_i) begin
        age_m++;
      end
      assert (age_t < 3 && age_m < 3)
        else abort_run("A pending channel was not delivered while the link was ready");
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  task automatic write_reg(input logic [1:0] addr, input logic [3:0] be, input logic [31:0] d);
    @(posedge clk_i);
    wr_en_i     <= 1'b1;
    wr_addr_i   <= addr;
    wr_be_i     <= be;
    wr_data_i   <= d;
    cfg_ready_i <= 1'b0;
  endtask

  // Kind 0 stalls the link, kind 1 keeps it ready, kind 2 toggles ready at random
  task automatic run_phase(input int kind, input int len);
    for (int c = 0; c < len; c++) begin
      @(posedge clk_i);
      wr_en_i     <= $random(seed);
      wr_addr_i   <= $random(seed);
      wr_be_i     <= $random(seed);
      wr_data_i   <= $random(seed);
      cfg_ready_i <= (kind == 2) ? $random(seed) : (kind == 1);
    end
  endtask

  task automatic drain_link();
    int waited;
    waited = 0;
    @(posedge clk_i);
    wr_en_i     <= 1'b0;
    cfg_ready_i <= 1'b1;
    @(negedge clk_i);
    while (cfg_valid_o) begin
      waited++;
      if (waited > 20) abort_run("The link kept its valid high with ready held high");
      @(negedge clk_i);
    end
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    wr_en_i     = 1'b0;
    wr_addr_i   = '0;
    wr_be_i     = '0;
    wr_data_i   = '0;
    cfg_ready_i = 1'b0;
    error_count = 0;
    seed        = 23955;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Both channels stall together, the timer must win the first tie
    write_reg(`CFG_ADDR_TIMER, 4'hf, 32'h8000_1234);
    write_reg(`CFG_ADDR_MODE, 4'h3, 32'h0000_0a57);
    // Partial overwrite during the stall, only the merged word may leave
    write_reg(`CFG_ADDR_TIMER, 4'h1, 32'h0000_00ff);
    run_phase(0, 3);
    drain_link();
    for (int p = 0; p < 16; p++) begin
      run_phase($unsigned($random(seed)) % 3, 16 + $unsigned($random(seed)) % 24);
    end
    drain_link();
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cfg_deposit_pkg.sv
cfg_regs.sv
stream_deposit.sv
cfg_link_tx.sv
cfg_deposit_top.sv
cfg_deposit_sva.sv
tb_cfg_deposit.sv

// ==== Bender.yml ====
package:
  name: cfg_deposit

export_include_dirs:
  - .

sources:
  - cfg_deposit_pkg.sv
  - cfg_regs.sv
  - stream_deposit.sv
  - cfg_link_tx.sv
  - cfg_deposit_top.sv
  - target: test
    files:
      - cfg_deposit_sva.sv
      - tb_cfg_deposit.sv
